/* Makefile */
TOP = tb_cpu_to_fpga_tx

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f

run: compile
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

/* compile.f */
verilog/tx_cfg_pkg.sv
verilog/tx_types_pkg.sv
verilog/tx_fifo.sv
verilog/tx_tail_monitor.sv
verilog/tx_fetch_gen.sv
verilog/tx_dsc_dispatch.sv
verilog/cpu_to_fpga_tx.sv
tests/tb_cpu_to_fpga_tx.sv

/* tests/tb_cpu_to_fpga_tx.sv */
`timescale 1ns/1ps

module tb_cpu_to_fpga_tx
  import tx_cfg_pkg::*, tx_types_pkg::*;
();

  localparam int ring_len = 64;
  localparam int n_rand = 1200;
  localparam int n_ops = n_rand + 40;
  localparam int timeout_cycles = n_ops * 40;
  // Writebacks in flight are kept below the prio FIFO depth.
  localparam int prio_headroom = 24;

  logic                      clk = 1'b0;
  logic                      rst;
  logic                      tail_wr_en;
  logic [queue_id_width-1:0] tail_wr_queue;
  logic [ptr_width-1:0]      tail_wr_data;
  logic                      base_wr_en;
  logic [queue_id_width-1:0] base_wr_queue;
  logic [addr_width-1:0]     base_wr_data;
  logic [ptr_width:0]        rb_size;
  logic                      rddm_write;
  logic [addr_width-1:0]     rddm_address;
  logic [wb_width-1:0]       rddm_writedata;
  logic                      rddm_desc_valid;
  rddm_desc_t                rddm_desc_data;
  logic                      rddm_desc_ready;
  logic                      rddm_prio_valid;
  rddm_desc_t                rddm_prio_data;
  logic                      rddm_prio_ready;
  logic [31:0]               ignored_cnt;
  logic [31:0]               empty_cnt;
  logic [31:0]               dsc_cnt;
  logic [31:0]               dsc_read_cnt;

  ////////////////////
  // Reference model.
  ////////////////////

  logic [ptr_width-1:0]  m_tail [nb_queues];
  logic [addr_width-1:0] m_base [nb_queues];
  bit                    sp;
  ring_state_t           s_item;
  ring_state_t           st_q [$];
  bit                    fg_second;
  ring_state_t           fg_wrap;
  bit                    fg_rv;
  rddm_desc_t            fg_req;
  rddm_desc_t            exp_desc [$];
  bit                    d_rv;
  rddm_desc_t            d_req;
  int                    last_q;
  logic [ptr_width-1:0]  last_head;
  rddm_desc_t            exp_prio [$];
  int unsigned           m_ignored;
  int unsigned           m_empty;
  int unsigned           m_dsc;
  int unsigned           m_read;
  int unsigned           ready_pct;

  cpu_to_fpga_tx dut0 (
    .clk             (clk),
    .rst             (rst),
    .tail_wr_en      (tail_wr_en),
    .tail_wr_queue   (tail_wr_queue),
    .tail_wr_data    (tail_wr_data),
    .base_wr_en      (base_wr_en),
    .base_wr_queue   (base_wr_queue),
    .base_wr_data    (base_wr_data),
    .rb_size         (rb_size),
    .rddm_write      (rddm_write),
    .rddm_address    (rddm_address),
    .rddm_writedata  (rddm_writedata),
    .rddm_desc_valid (rddm_desc_valid),
    .rddm_desc_data  (rddm_desc_data),
    .rddm_desc_ready (rddm_desc_ready),
    .rddm_prio_valid (rddm_prio_valid),
    .rddm_prio_data  (rddm_prio_data),
    .rddm_prio_ready (rddm_prio_ready),
    .ignored_cnt     (ignored_cnt),
    .empty_cnt       (empty_cnt),
    .dsc_cnt         (dsc_cnt),
    .dsc_read_cnt    (dsc_read_cnt)
  );

  always #5 clk = ~clk;

  task automatic check(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  // Padding, descriptor flag at bit 25, head at 24:9, queue at 8:6.
  function automatic logic [63:0] dst_addr(logic flag, logic [ptr_width-1:0] head,
                                           logic [queue_id_width-1:0] q);
    return (64'(flag) << 25) | (64'(head) << 9) | (64'(q) << 6);
  endfunction

  function automatic rddm_desc_t fetch_req(logic [queue_id_width-1:0] q,
                                           logic [ptr_width-1:0] head,
                                           logic [addr_width-1:0] base, int n);
    rddm_desc_t r;
    r.src_addr = base + 64'(head) * 64'(flit_bytes);
    r.dst_addr = dst_addr(1'b1, head, q);
    r.nb_dwords = 18'(n * 16);
    r.descriptor_id = 8'd2;
    r.single_dst = 1'b1;
    return r;
  endfunction

  task automatic compare_req(string name, rddm_desc_t got, rddm_desc_t exp);
    check({name, ".src_addr"}, got.src_addr, exp.src_addr);
    check({name, ".dst_addr"}, got.dst_addr, exp.dst_addr);
    check({name, ".nb_dwords"}, 64'(got.nb_dwords), 64'(exp.nb_dwords));
    check({name, ".descriptor_id"}, 64'(got.descriptor_id), 64'(exp.descriptor_id));
    check({name, ".single_dst"}, 64'(got.single_dst), 64'(exp.single_dst));
  endtask

  task automatic model_reset();
    for (int i = 0; i < nb_queues; i++) begin
      m_tail[i] = '0;
    end
    sp = 1'b0;
    fg_second = 1'b0;
    fg_rv = 1'b0;
    d_rv = 1'b0;
    last_q = -1;
    st_q.delete();
    exp_desc.delete();
    exp_prio.delete();
    m_ignored = 0;
    m_empty = 0;
    m_dsc = 0;
    m_read = 0;
  endtask

  // One clock edge of the model, using the inputs the DUT samples at it.
  task automatic model_step();
    bit                        alm;
    bit                        accept;
    ring_state_t               item;
    int                        n;
    logic [queue_id_width-1:0] wq;
    logic [ptr_width-1:0]      wh;
    check("ignored_cnt", 64'(ignored_cnt), 64'(m_ignored));
    check("empty_cnt", 64'(empty_cnt), 64'(m_empty));
    check("dsc_cnt", 64'(dsc_cnt), 64'(m_dsc));
    check("dsc_read_cnt", 64'(dsc_read_cnt), 64'(m_read));
    alm = (st_q.size() > state_fifo_alm_full) || (exp_desc.size() > desc_fifo_alm_full) ||
          (exp_prio.size() > prio_fifo_alm_full);
    accept = tail_wr_en && !alm;

    // Output ports.
    check("rddm_desc_valid", 64'(rddm_desc_valid), 64'(exp_desc.size() != 0));
    if (exp_desc.size() != 0) begin
      compare_req("rddm_desc_data", rddm_desc_data, exp_desc[0]);
      if (rddm_desc_ready) begin
        void'(exp_desc.pop_front());
      end
    end
    check("rddm_prio_valid", 64'(rddm_prio_valid), 64'(exp_prio.size() != 0));
    if (exp_prio.size() != 0) begin
      compare_req("rddm_prio_data", rddm_prio_data, exp_prio[0]);
      if (rddm_prio_ready) begin
        void'(exp_prio.pop_front());
      end
    end

    // Fetch stage.
    if (fg_rv) begin
      exp_desc.push_back(fg_req);
    end
    if (fg_second) begin
      fg_req = fetch_req(fg_wrap.queue_id, '0, fg_wrap.base, int'(fg_wrap.tail));
      m_dsc += 32'(fg_wrap.tail);
      fg_rv = 1'b1;
      fg_second = 1'b0;
    end else if (st_q.size() != 0) begin
      item = st_q.pop_front();
      if (item.tail > item.head) begin
        n = int'(item.tail) - int'(item.head);
      end else begin
        n = ring_len - int'(item.head);
      end
      fg_req = fetch_req(item.queue_id, item.head, item.base, n);
      m_dsc += 32'(n);
      fg_rv = 1'b1;
      fg_second = (item.tail <= item.head) && (item.tail != '0);
      fg_wrap = item;
    end else begin
      fg_rv = 1'b0;
    end

    // Tail table and admission.
    if (sp) begin
      if (s_item.head == s_item.tail) begin
        m_empty++;
      end else begin
        st_q.push_back(s_item);
      end
    end
    sp = accept;
    if (accept) begin
      s_item.queue_id = tail_wr_queue;
      s_item.head = m_tail[tail_wr_queue];
      s_item.tail = tail_wr_data;
      s_item.base = m_base[tail_wr_queue];
      m_tail[tail_wr_queue] = tail_wr_data;
    end
    if (tail_wr_en && alm) begin
      m_ignored++;
    end
    if (base_wr_en) begin
      m_base[base_wr_queue] = base_wr_data;
    end

    // Writeback dispatch.
    if (d_rv) begin
      exp_prio.push_back(d_req);
    end
    d_rv = rddm_write && rddm_address[25];
    if (d_rv) begin
      wq = rddm_address[8:6];
      if (last_q == int'(wq)) begin
        wh = ptr_width'((int'(last_head) + 1) % ring_len);
      end else begin
        wh = rddm_address[24:9];
      end
      last_q = int'(wq);
      last_head = wh;
      m_read++;
      d_req.src_addr = rddm_writedata[63:0];
      d_req.dst_addr = dst_addr(1'b0, wh, wq);
      d_req.nb_dwords = 18'((rddm_writedata[95:64] + 32'd3) / 32'd4);
      d_req.descriptor_id = 8'd1;
      d_req.single_dst = 1'b1;
    end
  endtask

  function automatic bit model_idle();
    return st_q.size() == 0 && !sp && !fg_second && !fg_rv && exp_desc.size() == 0 &&
           !d_rv && exp_prio.size() == 0;
  endfunction

  task automatic tick();
    @(posedge clk);
    if (rst) begin
      model_reset();
    end else begin
      model_step();
    end
    tail_wr_en <= 1'b0;
    base_wr_en <= 1'b0;
    rddm_write <= 1'b0;
    rddm_desc_ready <= $urandom_range(99) < ready_pct;
    rddm_prio_ready <= $urandom_range(99) < ready_pct;
  endtask

  task automatic write_tail(int q, int t);
    tail_wr_en <= 1'b1;
    tail_wr_queue <= queue_id_width'(q);
    tail_wr_data <= ptr_width'(t);
  endtask

  task automatic write_back(int q, int head, bit flag, int len, logic [63:0] paddr);
    rddm_write <= 1'b1;
    rddm_address <= dst_addr(flag, ptr_width'(head), queue_id_width'(q));
    rddm_writedata <= {{(wb_width - 96){1'b0}}, 32'(len), paddr};
  endtask

  function automatic int unsigned pct_for_phase(int phase);
    case (phase % 4)
      0: return 90;
      1: return 10;
      2: return 60;
      default: return 5;
    endcase
  endfunction

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("Timeout: the pipeline did not finish in %0d cycles", timeout_cycles);
    $display("Test FAILED");
    $fatal(1);
  end

  initial begin
    int                    q;
    int                    t;
    logic [addr_width-1:0] rnd_addr;
    void'($urandom(63372));
    ready_pct = 100;
    rst <= 1'b1;
    tail_wr_en <= 1'b0;
    tail_wr_queue <= '0;
    tail_wr_data <= '0;
    base_wr_en <= 1'b0;
    base_wr_queue <= '0;
    base_wr_data <= '0;
    rb_size <= (ptr_width + 1)'(ring_len);
    rddm_write <= 1'b0;
    rddm_address <= '0;
    rddm_writedata <= '0;
    rddm_desc_ready <= 1'b1;
    rddm_prio_ready <= 1'b1;
    tick();
    tick();
    rst <= 1'b0;

    // Ring base addresses, 64-byte aligned.
    for (int i = 0; i < nb_queues; i++) begin
      rnd_addr = {$urandom, $urandom};
      base_wr_en <= 1'b1;
      base_wr_queue <= queue_id_width'(i);
      base_wr_data <= rnd_addr & 64'hffff_ffff_ffff_ffc0;
      tick();
    end

    ////////////////////
    // Directed cases.
    ////////////////////

    write_tail(0, 5);
    tick();
    // Wrap with a nonzero tail, two requests.
    write_tail(0, 2);
    tick();
    write_tail(0, 0);
    tick();
    // Same tail again is an empty range.
    write_tail(0, 0);
    tick();
    write_back(1, 62, 1'b1, 100, 64'h1000);
    tick();
    write_back(1, 7, 1'b1, 1, 64'h2000);
    tick();
    write_back(1, 9, 1'b1, 4, 64'h3000);
    tick();
    write_back(2, 5, 1'b1, 65, 64'h4000);
    tick();
    write_back(3, 11, 1'b0, 8, 64'h5000);
    tick();
    write_back(2, 30, 1'b1, 3, 64'h6000);
    tick();

    ////////////////////
    // Random traffic with back-pressure.
    ////////////////////

    for (int i = 0; i < n_rand; i++) begin
      if (i % 300 == 0) begin
        ready_pct = pct_for_phase(i / 300);
      end
      if ($urandom_range(99) < 30) begin
        q = int'($urandom_range(nb_queues - 1));
        if ($urandom_range(9) == 0) begin
          t = int'(m_tail[q]);
        end else begin
          t = int'($urandom_range(ring_len - 1));
        end
        write_tail(q, t);
      end
      if (int'(exp_prio.size()) + int'(d_rv) < prio_headroom && $urandom_range(99) < 30) begin
        rnd_addr = {$urandom, $urandom};
        write_back(int'($urandom_range(2)), int'($urandom_range(ring_len - 1)),
                   $urandom_range(9) != 0, int'($urandom_range(3000, 1)), rnd_addr);
      end
      tick();
    end

    // Drain everything that is still in flight.
    ready_pct = 100;
    while (!model_idle()) begin
      tick();
    end
    repeat (4) tick();
    @(negedge clk);
    check("ignored_cnt", 64'(ignored_cnt), 64'(m_ignored));
    check("empty_cnt", 64'(empty_cnt), 64'(m_empty));
    check("dsc_cnt", 64'(dsc_cnt), 64'(m_dsc));
    check("dsc_read_cnt", 64'(dsc_read_cnt), 64'(m_read));
    $display("Test OK");
    $finish;
  end

endmodule

/* verilog/cpu_to_fpga_tx.sv */
`timescale 1ns/1ps

module cpu_to_fpga_tx
  import tx_cfg_pkg::*, tx_types_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      tail_wr_en,
  input  logic [queue_id_width-1:0] tail_wr_queue,
  input  logic [ptr_width-1:0]      tail_wr_data,
  input  logic                      base_wr_en,
  input  logic [queue_id_width-1:0] base_wr_queue,
  input  logic [addr_width-1:0]     base_wr_data,
  input  logic [ptr_width:0]        rb_size,
  input  logic                      rddm_write,
  input  logic [addr_width-1:0]     rddm_address,
  input  logic [wb_width-1:0]       rddm_writedata,
  output logic                      rddm_desc_valid,
  output rddm_desc_t                rddm_desc_data,
  input  logic                      rddm_desc_ready,
  output logic                      rddm_prio_valid,
  output rddm_desc_t                rddm_prio_data,
  input  logic                      rddm_prio_ready,
  output logic [31:0]               ignored_cnt,
  output logic [31:0]               empty_cnt,
  output logic [31:0]               dsc_cnt,
  output logic [31:0]               dsc_read_cnt
);

  ring_state_t state_in_data;
  logic        state_in_valid;
  ring_state_t state_out_data;
  logic        state_out_valid;
  logic        state_out_ready;
  logic        state_alm_full;

  rddm_desc_t  desc_in_data;
  logic        desc_in_valid;
  logic        desc_alm_full;

  rddm_desc_t  prio_in_data;
  logic        prio_in_valid;
  logic        prio_alm_full;

  ////////////////////
  // Descriptor fetch.
  ////////////////////

  tx_tail_monitor tail_monitor (
    .clk            (clk),
    .rst            (rst),
    .tail_wr_en     (tail_wr_en),
    .tail_wr_queue  (tail_wr_queue),
    .tail_wr_data   (tail_wr_data),
    .base_wr_en     (base_wr_en),
    .base_wr_queue  (base_wr_queue),
    .base_wr_data   (base_wr_data),
    .state_alm_full (state_alm_full),
    .desc_alm_full  (desc_alm_full),
    .prio_alm_full  (prio_alm_full),
    .state_data     (state_in_data),
    .state_valid    (state_in_valid),
    .ignored_cnt    (ignored_cnt),
    .empty_cnt      (empty_cnt)
  );

  tx_fifo #(
    .payload_t       (ring_state_t),
    .depth           (state_fifo_depth),
    .alm_full_thresh (state_fifo_alm_full)
  ) state_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (state_in_data),
    .in_valid  (state_in_valid),
    .in_ready  (),
    .out_data  (state_out_data),
    .out_valid (state_out_valid),
    .out_ready (state_out_ready),
    .alm_full  (state_alm_full)
  );

  tx_fetch_gen fetch_gen (
    .clk         (clk),
    .rst         (rst),
    .rb_size     (rb_size),
    .state_data  (state_out_data),
    .state_valid (state_out_valid),
    .state_ready (state_out_ready),
    .req_data    (desc_in_data),
    .req_valid   (desc_in_valid),
    .dsc_cnt     (dsc_cnt)
  );

  tx_fifo #(
    .payload_t       (rddm_desc_t),
    .depth           (desc_fifo_depth),
    .alm_full_thresh (desc_fifo_alm_full)
  ) desc_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (desc_in_data),
    .in_valid  (desc_in_valid),
    .in_ready  (),
    .out_data  (rddm_desc_data),
    .out_valid (rddm_desc_valid),
    .out_ready (rddm_desc_ready),
    .alm_full  (desc_alm_full)
  );

  ////////////////////
  // Packet requests.
  ////////////////////

  tx_dsc_dispatch dsc_dispatch (
    .clk            (clk),
    .rst            (rst),
    .rb_size        (rb_size),
    .rddm_write     (rddm_write),
    .rddm_address   (rddm_address),
    .rddm_writedata (rddm_writedata),
    .req_data       (prio_in_data),
    .req_valid      (prio_in_valid),
    .dsc_read_cnt   (dsc_read_cnt)
  );

  tx_fifo #(
    .payload_t       (rddm_desc_t),
    .depth           (prio_fifo_depth),
    .alm_full_thresh (prio_fifo_alm_full)
  ) prio_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (prio_in_data),
    .in_valid  (prio_in_valid),
    .in_ready  (),
    .out_data  (rddm_prio_data),
    .out_valid (rddm_prio_valid),
    .out_ready (rddm_prio_ready),
    .alm_full  (prio_alm_full)
  );

endmodule

/* verilog/tx_cfg_pkg.sv */
package tx_cfg_pkg;

  ////////////////////
  // Ring geometry.
  ////////////////////

  localparam int nb_queues = 8;
  localparam int queue_id_width = $clog2(nb_queues);
  localparam int ptr_width = 16;
  localparam int addr_width = 64;
  localparam int dword_cnt_width = 18;
  localparam int wb_width = 512;

  // One descriptor occupies a full 64-byte flit.
  localparam int flit_bytes = 64;
  localparam int dwords_per_flit = flit_bytes / 4;

  ////////////////////
  // FIFO sizing.
  ////////////////////

  localparam int state_fifo_depth = 16;
  localparam int state_fifo_alm_full = 10;
  localparam int desc_fifo_depth = 64;
  localparam int desc_fifo_alm_full = 48;
  localparam int prio_fifo_depth = 32;
  localparam int prio_fifo_alm_full = 20;

  // Tags that keep descriptor reads apart from packet reads.
  localparam logic [7:0] desc_req_id = 8'd2;
  localparam logic [7:0] pkt_req_id = 8'd1;

endpackage

/* verilog/tx_dsc_dispatch.sv */
`timescale 1ns/1ps

module tx_dsc_dispatch
  import tx_cfg_pkg::*, tx_types_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [ptr_width:0]    rb_size,
  input  logic                  rddm_write,
  input  logic [addr_width-1:0] rddm_address,
  input  logic [wb_width-1:0]   rddm_writedata,
  output rddm_desc_t            req_data,
  output logic                  req_valid,
  output logic [31:0]           dsc_read_cnt
);

  rddm_dst_addr_t          wb_addr;
  pcie_tx_dsc_t            wb_dsc;
  logic                    is_dsc;
  logic [ptr_width-1:0]    rb_mask;
  logic [queue_id_width:0] last_queue;  // top bit set means no queue yet
  logic [ptr_width-1:0]    last_head;
  logic [ptr_width-1:0]    head;
  rddm_dst_addr_t          pkt_dst;

  assign wb_addr = rddm_address;
  assign wb_dsc = rddm_writedata[$bits(pcie_tx_dsc_t)-1:0];
  assign is_dsc = rddm_write && wb_addr.descriptor;

  // Ring length is a power of two.
  assign rb_mask = ptr_width'(rb_size - 1'b1);

  // A burst of writebacks for one queue walks the ring one entry at a time.
  always_comb begin
    if (last_queue == {1'b0, wb_addr.queue_id}) begin
      head = (last_head + 1'b1) & rb_mask;
    end else begin
      head = wb_addr.head;
    end
    pkt_dst = wb_addr;
    pkt_dst.descriptor = 1'b0;
    pkt_dst.head = head;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid <= 1'b0;
      last_queue <= {1'b1, {queue_id_width{1'b0}}};
      dsc_read_cnt <= '0;
    end else begin
      req_valid <= is_dsc;
      if (is_dsc) begin
        last_queue <= {1'b0, wb_addr.queue_id};
        last_head <= head;
        dsc_read_cnt <= dsc_read_cnt + 1'b1;
      end
    end
  end

  // Packet read request.
  always_ff @(posedge clk) begin
    if (is_dsc) begin
      req_data.src_addr <= wb_dsc.addr;
      req_data.dst_addr <= pkt_dst;
      req_data.nb_dwords <= dword_cnt_width'(((wb_dsc.length - 1'b1) >> 2) + 1'b1);
      req_data.descriptor_id <= pkt_req_id;
      req_data.single_dst <= 1'b1;
    end
  end

  // Software never posts an empty packet.
  assert property (@(posedge clk) disable iff (rst) is_dsc |-> wb_dsc.length != '0)
    else $error("zero length descriptor");

endmodule

/* verilog/tx_fetch_gen.sv */
`timescale 1ns/1ps

module tx_fetch_gen
  import tx_cfg_pkg::*, tx_types_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic [ptr_width:0] rb_size,
  input  ring_state_t        state_data,
  input  logic               state_valid,
  output logic               state_ready,
  output rddm_desc_t         req_data,
  output logic               req_valid,
  output logic [31:0]        dsc_cnt
);

  logic                 second_pend;
  ring_state_t          wrap_state;
  logic                 pop;
  logic                 wraps;
  logic [ptr_width-1:0] first_flits;

  // Builds a descriptor read for nb_flits entries starting at head.
  function automatic rddm_desc_t make_req(
    input logic [queue_id_width-1:0] queue_id,
    input logic [ptr_width-1:0]      head,
    input logic [addr_width-1:0]     base,
    input logic [ptr_width-1:0]      nb_flits
  );
    rddm_desc_t     req;
    rddm_dst_addr_t dst;
    req = '0;
    dst = '0;
    dst.descriptor = 1'b1;
    dst.head = head;
    dst.queue_id = queue_id;
    req.src_addr = base + addr_width'(head) * addr_width'(flit_bytes);
    req.dst_addr = dst;
    req.nb_dwords = dword_cnt_width'(nb_flits) * dword_cnt_width'(dwords_per_flit);
    req.descriptor_id = desc_req_id;
    req.single_dst = 1'b1;
    return req;
  endfunction

  // Hold the state FIFO while the second half of a wrap goes out.
  assign state_ready = !second_pend;
  assign pop = state_valid && state_ready;
  assign wraps = state_data.tail <= state_data.head;

  always_comb begin
    if (wraps) begin
      first_flits = ptr_width'(rb_size - {1'b0, state_data.head});
    end else begin
      first_flits = state_data.tail - state_data.head;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      wrap_state <= state_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      second_pend <= 1'b0;
      req_valid <= 1'b0;
      dsc_cnt <= '0;
    end else begin
      req_valid <= 1'b0;
      second_pend <= 1'b0;
      if (second_pend) begin
        req_valid <= 1'b1;
        dsc_cnt <= dsc_cnt + 32'(wrap_state.tail);
      end else if (pop) begin
        req_valid <= 1'b1;
        // A zero tail means the first request already reaches the ring end.
        second_pend <= wraps && (state_data.tail != '0);
        dsc_cnt <= dsc_cnt + 32'(first_flits);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (second_pend) begin
      req_data <= make_req(wrap_state.queue_id, '0, wrap_state.base, wrap_state.tail);
    end else if (pop) begin
      req_data <= make_req(state_data.queue_id, state_data.head, state_data.base, first_flits);
    end
  end

  // Heads come from earlier tail writes and must stay inside the ring.
  assert property (@(posedge clk) disable iff (rst) pop |-> {1'b0, state_data.head} < rb_size)
    else $error("ring head beyond rb_size");

endmodule

/* verilog/tx_fifo.sv */
`timescale 1ns/1ps

module tx_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int depth = 16,
  parameter int alm_full_thresh = 12
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready,
  output logic     alm_full
);

  payload_t mem [depth];

  logic [$clog2(depth)-1:0] wr_ptr;
  logic [$clog2(depth)-1:0] rd_ptr;
  logic [$clog2(depth):0]   occup;
  logic                     push;
  logic                     pop;

  assign push = in_valid && in_ready;
  assign pop = out_valid && out_ready;

  assign in_ready = int'(occup) < depth;
  assign out_valid = occup != '0;
  assign out_data = mem[rd_ptr];
  assign alm_full = int'(occup) > alm_full_thresh;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occup <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        occup <= occup + 1'b1;
      end else if (pop && !push) begin
        occup <= occup - 1'b1;
      end
    end
  end

  // Tail admission keeps enough headroom above the threshold for every
  // request already in flight upstream.
  assert property (@(posedge clk) disable iff (rst) in_valid |-> in_ready)
    else $error("tx_fifo overflow");

endmodule

/* verilog/tx_tail_monitor.sv */
`timescale 1ns/1ps

module tx_tail_monitor
  import tx_cfg_pkg::*, tx_types_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      tail_wr_en,
  input  logic [queue_id_width-1:0] tail_wr_queue,
  input  logic [ptr_width-1:0]      tail_wr_data,
  input  logic                      base_wr_en,
  input  logic [queue_id_width-1:0] base_wr_queue,
  input  logic [addr_width-1:0]     base_wr_data,
  input  logic                      state_alm_full,
  input  logic                      desc_alm_full,
  input  logic                      prio_alm_full,
  output ring_state_t               state_data,
  output logic                      state_valid,
  output logic [31:0]               ignored_cnt,
  output logic [31:0]               empty_cnt
);

  logic [ptr_width-1:0]  tails [nb_queues];
  logic [addr_width-1:0] bases [nb_queues];

  logic can_issue;
  logic accept;
  logic state_pend;

  // Any FIFO near full stops new fetches.
  assign can_issue = !state_alm_full && !desc_alm_full && !prio_alm_full;
  assign accept = tail_wr_en && can_issue;

  ////////////////////
  // Queue table.
  ////////////////////

  always_ff @(posedge clk) begin
    if (base_wr_en) begin
      bases[base_wr_queue] <= base_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < nb_queues; i++) begin
        tails[i] <= '0;
      end
    end else if (accept) begin
      tails[tail_wr_queue] <= tail_wr_data;
    end
  end

  ////////////////////
  // State snapshot.
  ////////////////////

  // The old tail becomes the head of the range to fetch.
  always_ff @(posedge clk) begin
    if (accept) begin
      state_data.queue_id <= tail_wr_queue;
      state_data.head <= tails[tail_wr_queue];
      state_data.tail <= tail_wr_data;
      state_data.base <= bases[tail_wr_queue];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_pend <= 1'b0;
      ignored_cnt <= '0;
      empty_cnt <= '0;
    end else begin
      state_pend <= accept;
      if (tail_wr_en && !can_issue) begin
        ignored_cnt <= ignored_cnt + 1'b1;
      end
      // Nothing new to read.
      if (state_pend && (state_data.head == state_data.tail)) begin
        empty_cnt <= empty_cnt + 1'b1;
      end
    end
  end

  assign state_valid = state_pend && (state_data.head != state_data.tail);

endmodule

/* verilog/tx_types_pkg.sv */
package tx_types_pkg;
  import tx_cfg_pkg::*;

  // Snapshot of one ring taken on a tail write.
  typedef struct packed {
    logic [queue_id_width-1:0] queue_id;
    logic [ptr_width-1:0]      head;
    logic [ptr_width-1:0]      tail;
    logic [addr_width-1:0]     base;
  } ring_state_t;

  // Read data mover request.
  typedef struct packed {
    logic [addr_width-1:0]      src_addr;
    logic [addr_width-1:0]      dst_addr;
    logic [dword_cnt_width-1:0] nb_dwords;
    logic [7:0]                 descriptor_id;
    logic                       single_dst;
  } rddm_desc_t;

  // Metadata carried in the destination address of a read.
  // The write comes back on the same address, so the fields return with the data.
  typedef struct packed {
    logic [addr_width-ptr_width-queue_id_width-8:0] pad_hi;
    logic                                           descriptor;
    logic [ptr_width-1:0]                           head;
    logic [queue_id_width-1:0]                      queue_id;
    logic [5:0]                                     pad_lo;
  } rddm_dst_addr_t;

  // Low part of a host descriptor as written back by the mover.
  typedef struct packed {
    logic [31:0]           length;
    logic [addr_width-1:0] addr;
  } pcie_tx_dsc_t;

endpackage
